/* hw/rammodel_macros.svh */
`ifndef RAMMODEL_MACROS_SVH
`define RAMMODEL_MACROS_SVH

// Byte address width of the AXI ports
`define RAMMODEL_ADDR_WIDTH 32

// Data bus width in bits, a whole number of bytes
`define RAMMODEL_DATA_WIDTH 32

// Memory depth as log2 of the number of data words
`define RAMMODEL_MEM_WORDS_LOG2 10

// Width of the latency counters
`define RAMMODEL_DELAY_WIDTH 16

// Default latencies in cycles
`define RAMMODEL_R_DELAY 25
`define RAMMODEL_W_DELAY 3

`endif

/* hw/axi_pkg.sv */
`include "rammodel_macros.svh"

package axi_pkg;

    // Burst type encoding as on the AXI AxBURST field
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // Address channel request, shared by AR and AW
    typedef struct packed {
        logic [`RAMMODEL_ADDR_WIDTH-1:0] addr;
        logic [7:0]                      len;
        logic [2:0]                      size;
        burst_e                          burst;
    } ax_req_t;

    // One beat on the W channel
    typedef struct packed {
        logic [`RAMMODEL_DATA_WIDTH-1:0]   data;
        logic [`RAMMODEL_DATA_WIDTH/8-1:0] strb;
        logic                              last;
    } w_beat_t;

    // One beat on the R channel
    typedef struct packed {
        logic [`RAMMODEL_DATA_WIDTH-1:0] data;
        logic                            last;
    } r_beat_t;

endpackage

/* hw/rammodel_pkg.sv */
`include "rammodel_macros.svh"

package rammodel_pkg;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_DELAY,
        RD_BEATS
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_DELAY,
        WR_RESP
    } wr_state_e;

    // What the address sequencer latches at burst start
    typedef struct packed {
        logic [`RAMMODEL_ADDR_WIDTH-1:0] addr;
        logic [7:0]                      len;
        logic [2:0]                      size;
        axi_pkg::burst_e                 burst;
    } beat_cmd_t;

    typedef struct packed {
        logic [`RAMMODEL_MEM_WORDS_LOG2-1:0] addr;
        logic [`RAMMODEL_DATA_WIDTH-1:0]     data;
        logic [`RAMMODEL_DATA_WIDTH/8-1:0]   strb;
    } store_wr_t;

endpackage

/* hw/rammodel_timing.sv */
`include "rammodel_macros.svh"

module rammodel_timing #(
    parameter int R_DELAY = `RAMMODEL_R_DELAY,
    parameter int W_DELAY = `RAMMODEL_W_DELAY
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ar_valid,
    output logic       ar_ready,
    input  logic [7:0] ar_len,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  logic       w_valid,
    output logic       w_ready,
    input  logic       w_last,
    input  logic       r_slot_free,
    input  logic       b_done,
    output logic       rreq_valid,
    output logic       breq_valid
);

    localparam int CW = `RAMMODEL_DELAY_WIDTH;

    // One cycle goes to leaving DELAY, so the read count starts two short
    // R_DELAY must be at least 2
    localparam logic [CW-1:0] R_LOAD = CW'(R_DELAY - 2);
    localparam logic [CW-1:0] W_LOAD = CW'(W_DELAY);

    rammodel_pkg::rd_state_e rd_state;
    rammodel_pkg::wr_state_e wr_state;
    logic [CW-1:0]           rd_cnt;
    logic [CW-1:0]           wr_cnt;
    logic [7:0]              rd_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= rammodel_pkg::RD_IDLE;
            rd_cnt   <= '0;
            rd_left  <= '0;
        end else begin
            case (rd_state)
                rammodel_pkg::RD_IDLE: begin
                    if (ar_valid) begin
                        rd_state <= rammodel_pkg::RD_DELAY;
                        rd_cnt   <= R_LOAD;
                        rd_left  <= ar_len;
                    end
                end
                rammodel_pkg::RD_DELAY: begin
                    if (rd_cnt == '0) begin
                        rd_state <= rammodel_pkg::RD_BEATS;
                    end else begin
                        rd_cnt <= rd_cnt - 1'b1;
                    end
                end
                rammodel_pkg::RD_BEATS: begin
                    // Beat counter only moves when a beat is issued
                    if (rreq_valid) begin
                        if (rd_left == 8'd0) begin
                            rd_state <= rammodel_pkg::RD_IDLE;
                        end else begin
                            rd_left <= rd_left - 8'd1;
                        end
                    end
                end
                default: begin
                    rd_state <= rammodel_pkg::RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= rammodel_pkg::WR_IDLE;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                rammodel_pkg::WR_IDLE: begin
                    if (aw_valid) begin
                        wr_state <= rammodel_pkg::WR_DATA;
                    end
                end
                rammodel_pkg::WR_DATA: begin
                    if (w_valid && w_last) begin
                        wr_state <= rammodel_pkg::WR_DELAY;
                        wr_cnt   <= W_LOAD;
                    end
                end
                rammodel_pkg::WR_DELAY: begin
                    if (wr_cnt == '0) begin
                        wr_state <= rammodel_pkg::WR_RESP;
                    end else begin
                        wr_cnt <= wr_cnt - 1'b1;
                    end
                end
                rammodel_pkg::WR_RESP: begin
                    // Hold off the next AW until the response is taken
                    if (b_done) begin
                        wr_state <= rammodel_pkg::WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= rammodel_pkg::WR_IDLE;
                end
            endcase
        end
    end

    assign ar_ready   = (rd_state == rammodel_pkg::RD_IDLE);
    assign aw_ready   = (wr_state == rammodel_pkg::WR_IDLE);
    assign w_ready    = (wr_state == rammodel_pkg::WR_DATA);

    assign rreq_valid = (rd_state == rammodel_pkg::RD_BEATS) && r_slot_free;
    assign breq_valid = (wr_state == rammodel_pkg::WR_DELAY) && (wr_cnt == '0);

endmodule

/* hw/rammodel_addr_gen.sv */
`include "rammodel_macros.svh"

module rammodel_addr_gen (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  rammodel_pkg::beat_cmd_t         cmd,
    input  logic                            step,
    output logic [`RAMMODEL_ADDR_WIDTH-1:0] addr
);

    localparam int AW = `RAMMODEL_ADDR_WIDTH;

    rammodel_pkg::beat_cmd_t cmd_q;
    logic [AW-1:0]           size_bytes;
    logic [AW-1:0]           wrap_mask;
    logic [AW-1:0]           incr_addr;
    logic [AW-1:0]           next_addr;

    always_comb begin
        size_bytes = AW'(1) << cmd_q.size;
        // Wrap window is (len+1) beats, a power of two for legal WRAP bursts
        wrap_mask  = ((AW'(cmd_q.len) + AW'(1)) << cmd_q.size) - AW'(1);
        // Unaligned start snaps to the beat boundary from the second beat on
        incr_addr  = (addr & ~(size_bytes - AW'(1))) + size_bytes;
        case (cmd_q.burst)
            axi_pkg::BURST_FIXED: begin
                next_addr = addr;
            end
            axi_pkg::BURST_WRAP: begin
                next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
            end
            default: begin
                next_addr = incr_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q <= '0;
            addr  <= '0;
        end else if (start) begin
            cmd_q <= cmd;
            addr  <= cmd.addr;
        end else if (step) begin
            addr <= next_addr;
        end
    end

endmodule

/* hw/rammodel_store.sv */
`include "rammodel_macros.svh"

module rammodel_store (
    input  logic                                clk,
    input  logic                                wr_en,
    input  rammodel_pkg::store_wr_t             wr,
    input  logic [`RAMMODEL_MEM_WORDS_LOG2-1:0] rd_addr,
    output logic [`RAMMODEL_DATA_WIDTH-1:0]     rd_data
);

    localparam int DW    = `RAMMODEL_DATA_WIDTH;
    localparam int BYTES = DW / 8;
    localparam int DEPTH = 1 << `RAMMODEL_MEM_WORDS_LOG2;

    logic [DW-1:0] mem [DEPTH];

    // Byte lanes with a clear strobe keep their old contents
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < BYTES; i++) begin
                if (wr.strb[i]) begin
                    mem[wr.addr][i*8 +: 8] <= wr.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hw/rammodel_top.sv */
`include "rammodel_macros.svh"

module rammodel_top #(
    parameter int R_DELAY = `RAMMODEL_R_DELAY,
    parameter int W_DELAY = `RAMMODEL_W_DELAY
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ar_valid,
    output logic             ar_ready,
    input  axi_pkg::ax_req_t ar,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  axi_pkg::ax_req_t aw,
    input  logic             w_valid,
    output logic             w_ready,
    input  axi_pkg::w_beat_t w,
    output logic             r_valid,
    input  logic             r_ready,
    output axi_pkg::r_beat_t r,
    output logic             b_valid,
    input  logic             b_ready
);

    localparam int AW        = `RAMMODEL_ADDR_WIDTH;
    localparam int WORD_BITS = `RAMMODEL_MEM_WORDS_LOG2;
    localparam int WORD_LSB  = $clog2(`RAMMODEL_DATA_WIDTH / 8);

    logic                            ar_fire;
    logic                            aw_fire;
    logic                            w_fire;
    logic                            rreq_valid;
    logic                            breq_valid;
    logic                            r_slot_free;
    rammodel_pkg::beat_cmd_t         rd_cmd;
    rammodel_pkg::beat_cmd_t         wr_cmd;
    logic [AW-1:0]                   rd_byte_addr;
    logic [AW-1:0]                   wr_byte_addr;
    logic [WORD_BITS-1:0]            rd_word_q;
    logic [WORD_BITS-1:0]            store_rd_addr;
    logic [`RAMMODEL_DATA_WIDTH-1:0] store_rd_data;
    rammodel_pkg::store_wr_t         store_wr;
    logic [7:0]                      r_len_q;
    logic [7:0]                      r_issued;
    logic                            rd_pend;
    logic                            rd_pend_last;
    logic                            r_load;

    assign ar_fire = ar_valid && ar_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // Slot counts as free when empty or emptied at this edge
    assign r_slot_free = !r_valid || r_ready;

    rammodel_timing #(
        .R_DELAY (R_DELAY),
        .W_DELAY (W_DELAY)
    ) u_timing (
        .clk         (clk),
        .rst         (rst),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar_len      (ar.len),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w_last      (w.last),
        .r_slot_free (r_slot_free),
        .b_done      (b_valid && b_ready),
        .rreq_valid  (rreq_valid),
        .breq_valid  (breq_valid)
    );

    assign rd_cmd = '{addr: ar.addr, len: ar.len, size: ar.size, burst: ar.burst};
    assign wr_cmd = '{addr: aw.addr, len: aw.len, size: aw.size, burst: aw.burst};

    rammodel_addr_gen u_rd_addr (
        .clk   (clk),
        .rst   (rst),
        .start (ar_fire),
        .cmd   (rd_cmd),
        .step  (rreq_valid),
        .addr  (rd_byte_addr)
    );

    rammodel_addr_gen u_wr_addr (
        .clk   (clk),
        .rst   (rst),
        .start (aw_fire),
        .cmd   (wr_cmd),
        .step  (w_fire),
        .addr  (wr_byte_addr)
    );

    // Re-read the last issued word while a fetched beat waits for the R slot
    assign store_rd_addr = rreq_valid ? rd_byte_addr[WORD_LSB +: WORD_BITS] : rd_word_q;

    assign store_wr = '{
        addr: wr_byte_addr[WORD_LSB +: WORD_BITS],
        data: w.data,
        strb: w.strb
    };

    rammodel_store u_store (
        .clk     (clk),
        .wr_en   (w_fire),
        .wr      (store_wr),
        .rd_addr (store_rd_addr),
        .rd_data (store_rd_data)
    );

    // Last flag is fixed at issue time, a new AR may arrive while it waits
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            r_len_q <= ar.len;
        end
        if (rreq_valid) begin
            rd_word_q    <= rd_byte_addr[WORD_LSB +: WORD_BITS];
            rd_pend_last <= (r_issued == r_len_q);
        end
        if (r_load) begin
            r.data <= store_rd_data;
            r.last <= rd_pend_last;
        end
    end

    assign r_load = rd_pend && r_slot_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_issued <= 8'd0;
            rd_pend  <= 1'b0;
            r_valid  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            if (ar_fire) begin
                r_issued <= 8'd0;
            end else if (rreq_valid) begin
                r_issued <= r_issued + 8'd1;
            end
            rd_pend <= rreq_valid || (rd_pend && !r_slot_free);
            if (r_load) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (breq_valid) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

endmodule

/* verif/rammodel_tb.sv */
`include "rammodel_macros.svh"

module rammodel_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int R_DELAY = `RAMMODEL_R_DELAY;
    localparam int W_DELAY = `RAMMODEL_W_DELAY;
    localparam int ROUNDS  = 12;
    // Fill beats plus every test burst both written and read at up to 16 beats each
    localparam int BEATS_MAX       = 1024 + (4 * ROUNDS + 2) * 2 * 16;
    localparam int WATCHDOG_CYCLES = BEATS_MAX * (R_DELAY + 4) + 2000;

    logic             clk = 1'b0;
    logic             rst;
    logic             ar_valid;
    logic             ar_ready;
    axi_pkg::ax_req_t ar;
    logic             aw_valid;
    logic             aw_ready;
    axi_pkg::ax_req_t aw;
    logic             w_valid;
    logic             w_ready;
    axi_pkg::w_beat_t w;
    logic             r_valid;
    logic             r_ready;
    axi_pkg::r_beat_t r;
    logic             b_valid;
    logic             b_ready;

    logic [31:0] lfsr = 32'h445f4ee0;
    int unsigned cycle = 0;
    // Byte model of the store keyed by byte address within the 4 KB window
    logic [7:0]  model_mem [int];

    rammodel_top dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [7:0] len,
                                              input logic [2:0] size, input axi_pkg::burst_e burst,
                                              input int n);
        logic [31:0] sz;
        logic [31:0] win;
        logic [31:0] wbase;
        sz    = 32'd1 << size;
        win   = (32'(len) + 32'd1) * sz;
        wbase = start - (start % win);
        case (burst)
            axi_pkg::BURST_FIXED: return start;
            axi_pkg::BURST_WRAP:  return wbase + ((start - wbase + 32'(n) * sz) % win);
            default: begin
                if (n == 0) return start;
                return (start & ~(sz - 32'd1)) + 32'(n) * sz;
            end
        endcase
    endfunction

    // Byte lanes that a beat at this address and size may drive
    function automatic logic [3:0] lane_mask(input logic [31:0] a, input logic [2:0] size);
        int         sz;
        int         lo;
        int         hi;
        logic [3:0] m;
        sz = 1 << size;
        lo = int'(a[1:0]);
        hi = (lo / sz) * sz + sz;
        for (int b = 0; b < 4; b++) begin
            m[b] = (b >= lo) && (b < hi);
        end
        return m;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] wb);
        return {~wb[15:0], wb[15:0] ^ 16'h3c5a};
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        int wb;
        wb = int'(a & 32'h0000_0ffc);
        return {model_mem[wb + 3], model_mem[wb + 2], model_mem[wb + 1], model_mem[wb]};
    endfunction

    task automatic check_equal(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0h, actual %0h", test, expected, actual);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", test);
        end
    endtask

    task automatic write_burst(input string name, input logic [31:0] addr, input logic [7:0] len,
                               input logic [2:0] size, input axi_pkg::burst_e burst,
                               input bit partial, input bit fill, input int b_hold);
        axi_pkg::w_beat_t beat;
        logic [31:0]      a;
        logic [31:0]      wb;
        int unsigned      last_edge;
        aw       <= '{addr: addr, len: len, size: size, burst: burst};
        aw_valid <= 1'b1;
        @(posedge clk);
        while (!aw_ready) @(posedge clk);
        aw_valid <= 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            a         = beat_addr(addr, len, size, burst, n);
            wb        = a & 32'h0000_0ffc;
            beat.data = fill ? fill_word(wb) : rand_bits(32);
            beat.strb = lane_mask(a, size) & (partial ? 4'(rand_bits(4)) : 4'hf);
            beat.last = (n == int'(len));
            w       <= beat;
            w_valid <= 1'b1;
            @(posedge clk);
            while (!w_ready) @(posedge clk);
            for (int b = 0; b < 4; b++) begin
                if (beat.strb[b]) begin
                    model_mem[int'(wb) + b] = beat.data[b*8 +: 8];
                end
            end
        end
        last_edge = cycle;
        w_valid <= 1'b0;
        b_ready <= (b_hold == 0);
        @(posedge clk);
        while (!b_valid) @(posedge clk);
        check_equal({name, " b latency"}, 64'(W_DELAY + 1), 64'(cycle - 1 - last_edge));
        check_equal({name, " w_ready after last"}, 64'(0), 64'(w_ready));
        check_equal({name, " aw_ready in resp"}, 64'(0), 64'(aw_ready));
        // Response held back so B and the next AW must both wait
        for (int i = 0; i < b_hold; i++) begin
            @(posedge clk);
            check_equal({name, " b hold"}, 64'(1), 64'(b_valid));
            check_equal({name, " aw_ready in resp"}, 64'(0), 64'(aw_ready));
        end
        if (b_hold > 0) begin
            b_ready <= 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic read_burst(input string name, input logic [31:0] addr, input logic [7:0] len,
                              input logic [2:0] size, input axi_pkg::burst_e burst,
                              input bit stall, output int unsigned latency);
        axi_pkg::r_beat_t prev;
        logic [31:0]      exp_word;
        int unsigned      ar_edge;
        int               n;
        bit               seen;
        bit               held;
        n       = 0;
        seen    = 1'b0;
        held    = 1'b0;
        latency = 0;
        ar       <= '{addr: addr, len: len, size: size, burst: burst};
        ar_valid <= 1'b1;
        r_ready  <= stall ? 1'(rand_bits(1)) : 1'b1;
        @(posedge clk);
        while (!ar_ready) @(posedge clk);
        ar_edge = cycle;
        ar_valid <= 1'b0;
        while (n <= int'(len)) begin
            if (stall) begin
                r_ready <= 1'(rand_bits(1));
            end
            @(posedge clk);
            if (held) begin
                check_equal({name, " r held"}, 64'(1), 64'(r_valid));
                check_equal({name, " r stable"}, {31'b0, prev}, {31'b0, r});
            end
            held = r_valid && !r_ready;
            prev = r;
            if (r_valid && !seen) begin
                seen    = 1'b1;
                latency = cycle - 1 - ar_edge;
            end
            if (r_valid && r_ready) begin
                exp_word = model_word(beat_addr(addr, len, size, burst, n));
                check_equal({name, " data"}, 64'(exp_word), 64'(r.data));
                check_equal({name, " last"}, 64'(n == int'(len)), 64'(r.last));
                n++;
            end
        end
        r_ready <= 1'b0;
        @(posedge clk);
        check_equal({name, " extra beat"}, 64'(0), 64'(r_valid));
    endtask

    // mode 0 is INCR at full width, mode 1 FIXED or WRAP, mode 2 any burst type
    task automatic round_trip(input string name, input int mode, input bit partial,
                              input bit stall);
        logic [31:0]     addr;
        logic [7:0]      len;
        logic [2:0]      size;
        axi_pkg::burst_e burst;
        logic [1:0]      pick;
        int unsigned     lat;
        pick = 2'(rand_bits(2));
        size = (mode == 0 || pick == 2'd3) ? 3'd2 : 3'(pick);
        pick = 2'(rand_bits(2));
        if (mode == 0) begin
            burst = axi_pkg::BURST_INCR;
        end else if (mode == 1) begin
            burst = pick[0] ? axi_pkg::BURST_WRAP : axi_pkg::BURST_FIXED;
        end else begin
            burst = (pick == 2'd0) ? axi_pkg::BURST_FIXED :
                    (pick == 2'd1) ? axi_pkg::BURST_WRAP : axi_pkg::BURST_INCR;
        end
        if (burst == axi_pkg::BURST_WRAP) begin
            len  = 8'((32'd2 << rand_bits(2)) - 32'd1);
            addr = rand_bits(12) & ~((32'd1 << size) - 32'd1);
        end else begin
            len  = 8'(rand_bits(4));
            addr = rand_bits(12);
        end
        write_burst(name, addr, len, size, burst, partial, 1'b0, int'(rand_bits(2)));
        read_burst(name, addr, len, size, burst, stall, lat);
        check_equal({name, " read latency"}, 64'(R_DELAY + 1), 64'(lat));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int unsigned lat;
        rst      = 1'b1;
        ar_valid = 1'b0;
        ar       = '0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        r_ready  = 1'b0;
        b_ready  = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_equal("reset ar_ready", 64'(1), 64'(ar_ready));
        check_equal("reset aw_ready", 64'(1), 64'(aw_ready));
        check_equal("reset w_ready", 64'(0), 64'(w_ready));
        check_equal("reset r_valid", 64'(0), 64'(r_valid));
        check_equal("reset b_valid", 64'(0), 64'(b_valid));

        // Whole store gets a known pattern so every read word has a model value
        for (int k = 0; k < 4; k++) begin
            write_burst("fill", 32'(k * 1024), 8'd255, 3'd2, axi_pkg::BURST_INCR,
                        1'b0, 1'b1, 0);
        end

        read_burst("read latency", 32'h0000_0124, 8'd0, 3'd2, axi_pkg::BURST_INCR, 1'b0, lat);
        check_equal("read latency", 64'(R_DELAY + 1), 64'(lat));

        for (int i = 0; i < ROUNDS; i++) round_trip("incr round trip", 0, 1'b0, 1'b0);
        for (int i = 0; i < ROUNDS; i++) round_trip("fixed and wrap", 1, 1'b0, 1'b0);
        for (int i = 0; i < ROUNDS; i++) round_trip("strobes", 2, 1'b1, 1'b0);
        write_burst("b hold", 32'h0000_0200, 8'd3, 3'd2, axi_pkg::BURST_INCR, 1'b0, 1'b0, 6);
        for (int i = 0; i < ROUNDS; i++) round_trip("read backpressure", 2, 1'b1, 1'b1);

        $display("** PASS **");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hw
hw/axi_pkg.sv
hw/rammodel_pkg.sv
hw/rammodel_timing.sv
hw/rammodel_addr_gen.sv
hw/rammodel_store.sv
hw/rammodel_top.sv
verif/rammodel_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := rammodel_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
